// ==== frame_params.svh ====
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

// Frame counter LFSR width
`define FRAME_LFSR_W 15

// CPU clocks per APU cycle
`define FRAME_APU_DIV 2

// LFSR states for the five match terms, counted from the all-zero state.
// These are the complements of the reference PLA terms, which decode an
// XOR register that reloads to all ones
`define FRAME_STEP0 15'h6F9E
`define FRAME_STEP1 15'h49FC
`define FRAME_STEP2 15'h532C
`define FRAME_STEP3 15'h75E0
`define FRAME_STEP4 15'h0E7A

// Fields of the 4017 register
`define FRAME_MODE_BIT 7
`define FRAME_INHIBIT_BIT 6

// Bit positions in the step vector
`define FRAME_LAST4 3
`define FRAME_LAST5 4

`endif

// ==== frame_pkg.sv ====
package frame_pkg;

`include "frame_params.svh"

	// CPU data bus byte
	typedef logic [7:0] byte_t;

	// Counter state
	typedef logic [`FRAME_LFSR_W-1:0] lfsr_t;

	// One bit per decoded match term
	typedef logic [4:0] step_t;

	// Register 4017 contents as used by the sequencer
	typedef struct packed {
		logic mode;        // 1 = five-step sequence
		logic irq_inhibit; // 1 = no frame interrupt
	} frame_cfg_t;

	// Clock pulses for the channel envelopes and sweeps
	typedef struct packed {
		logic quarter;
		logic half;
	} frame_evt_t;

	// Write hold FSM in the control block
	typedef enum logic {
		CTL_IDLE,
		CTL_PEND
	} ctl_state_t;

endpackage

// ==== frame_timer.sv ====
`include "frame_params.svh"

module frame_timer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  frame_pkg::frame_cfg_t cfg,
	input  logic                  restart,
	output logic                  apu_tick,
	output frame_pkg::step_t      step
);

	import frame_pkg::*;

	localparam int DIV = `FRAME_APU_DIV;
	localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam int W = `FRAME_LFSR_W;

	logic [DIV_W-1:0] div_cnt;
	lfsr_t            lfsr;
	lfsr_t            lfsr_next;
	logic             fb;
	step_t            match;
	logic             seq_end;

	// APU cycle divider
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (apu_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign apu_tick = (div_cnt == DIV_W'(DIV - 1));

	// Match decoder
	always_comb begin
		match = '0;
		match[0] = (lfsr == `FRAME_STEP0);
		match[1] = (lfsr == `FRAME_STEP1);
		match[2] = (lfsr == `FRAME_STEP2);
		match[`FRAME_LAST4] = (lfsr == `FRAME_STEP3) && !cfg.mode; // Four-step only
		match[`FRAME_LAST5] = (lfsr == `FRAME_STEP4) && cfg.mode;
	end

	assign seq_end = match[`FRAME_LAST4] | match[`FRAME_LAST5];

	// Shift left, feedback into bit 0
	assign fb = ~(lfsr[W-1] ^ lfsr[W-2]);
	assign lfsr_next = seq_end ? '0 : {lfsr[W-2:0], fb};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lfsr <= '0;
		end else if (restart) begin
			lfsr <= '0; // New sequence from the 4017 write
		end else if (apu_tick) begin
			lfsr <= lfsr_next;
		end
	end

	// A restart tick replaces whatever step the old sequence had
	assign step = (apu_tick && !restart) ? match : '0;

endmodule

// ==== frame_ctl.sv ====
`include "frame_params.svh"

module frame_ctl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  apu_tick,
	input  logic                  wr_4017,
	input  frame_pkg::byte_t      wdata,
	output frame_pkg::frame_cfg_t cfg,
	output logic                  restart,
	output logic                  force_evt
);

	import frame_pkg::*;

	ctl_state_t state;
	ctl_state_t state_next;
	byte_t      pend_data;
	frame_cfg_t pend_cfg;
	logic       apply;

	// Last byte written, waits for the APU cycle edge
	always_ff @(posedge clk) begin
		if (wr_4017) begin
			pend_data <= wdata;
		end
	end

	assign pend_cfg.mode = pend_data[`FRAME_MODE_BIT];
	assign pend_cfg.irq_inhibit = pend_data[`FRAME_INHIBIT_BIT];

	assign apply = (state == CTL_PEND) && apu_tick;

	always_comb begin
		state_next = state;
		if (wr_4017) begin
			state_next = CTL_PEND; // A newer write replaces the held one
		end else if (apply) begin
			state_next = CTL_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= CTL_IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg <= '0;
		end else if (apply) begin
			cfg <= pend_cfg;
		end
	end

	assign restart = apply;
	assign force_evt = apply && pend_cfg.mode; // Five-step clocks units at once

endmodule

// ==== frame_events.sv ====
`include "frame_params.svh"

module frame_events (
	input  logic                  clk,
	input  logic                  rst_n,
	input  frame_pkg::step_t      step,
	input  frame_pkg::frame_cfg_t cfg,
	input  logic                  force_evt,
	input  logic                  rd_4015,
	input  logic                  dmc_irq,
	output frame_pkg::frame_evt_t evt,
	output logic                  frame_irq_flag,
	output logic                  irq
);

	import frame_pkg::*;

	frame_evt_t evt_next;
	logic       last_step;
	logic       irq_set;
	logic       irq_clr;

	// Last step of the running sequence
	assign last_step = cfg.mode ? step[`FRAME_LAST5] : step[`FRAME_LAST4];

	always_comb begin
		evt_next.quarter = (|step) | force_evt;
		evt_next.half = step[1] | last_step | force_evt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			evt <= '0;
		end else begin
			evt <= evt_next;
		end
	end

	// Interrupt only at the end of a four-step sequence
	assign irq_set = step[`FRAME_LAST4] && !cfg.mode && !cfg.irq_inhibit;

	// A status read in the same cycle as a set misses it
	assign irq_clr = cfg.irq_inhibit || (rd_4015 && !irq_set);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			frame_irq_flag <= 1'b0;
		end else if (irq_clr) begin
			frame_irq_flag <= 1'b0;
		end else if (irq_set) begin
			frame_irq_flag <= 1'b1;
		end
	end

	assign irq = frame_irq_flag | dmc_irq; // Shared CPU interrupt line

endmodule

// ==== frame_counter.sv ====
module frame_counter (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wr_4017,
	input  frame_pkg::byte_t wdata,
	input  logic             rd_4015,
	input  logic             dmc_irq,
	output logic             quarter_frame,
	output logic             half_frame,
	output logic             irq,
	output logic             frame_irq_flag
);

	import frame_pkg::*;

	frame_cfg_t cfg;
	logic       restart;
	logic       force_evt;
	logic       apu_tick;
	step_t      step;
	frame_evt_t evt;

	frame_timer u_timer (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.restart  (restart),
		.apu_tick (apu_tick),
		.step     (step)
	);

	frame_ctl u_ctl (
		.clk       (clk),
		.rst_n     (rst_n),
		.apu_tick  (apu_tick),
		.wr_4017   (wr_4017),
		.wdata     (wdata),
		.cfg       (cfg),
		.restart   (restart),
		.force_evt (force_evt)
	);

	frame_events u_events (
		.clk            (clk),
		.rst_n          (rst_n),
		.step           (step),
		.cfg            (cfg),
		.force_evt      (force_evt),
		.rd_4015        (rd_4015),
		.dmc_irq        (dmc_irq),
		.evt            (evt),
		.frame_irq_flag (frame_irq_flag),
		.irq            (irq)
	);

	assign quarter_frame = evt.quarter;
	assign half_frame = evt.half;

endmodule

// ==== tb_clock.sv ====
module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== frame_assertions.sv ====
module frame_assertions (
	input logic             clk,
	input logic             rst_n,
	input frame_pkg::step_t step,
	input logic             quarter_frame,
	input logic             half_frame,
	input logic             irq,
	input logic             frame_irq_flag
);

	timeunit 1ns;
	timeprecision 1ps;

	a_quarter_single: assert property (@(posedge clk) disable iff (!rst_n)
		quarter_frame |=> !quarter_frame)
		else $error("quarter_frame high for two clocks in a row");

	a_half_single: assert property (@(posedge clk) disable iff (!rst_n)
		half_frame |=> !half_frame)
		else $error("half_frame high for two clocks in a row");

	a_half_has_quarter: assert property (@(posedge clk) disable iff (!rst_n)
		half_frame |-> quarter_frame)
		else $error("half_frame without quarter_frame");

	a_step_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(step))
		else $error("more than one step bit set");

	// Registers still hold their reset values here
	a_reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> !quarter_frame && !half_frame && !frame_irq_flag && !irq)
		else $error("output high in the first clock after reset");

endmodule

// ==== tb_frame_counter.sv ====
`include "frame_params.svh"

module tb_frame_counter;

	timeunit 1ns;
	timeprecision 1ps;

	import frame_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int IN_DELAY = 2;
	localparam int REC_WORDS = 7; // cmd data apu_cycles quarter half flag irq
	localparam int MAX_RECS = 16;
	localparam logic [3:0] CMD_END = 4'h0;
	localparam logic [3:0] CMD_WRITE = 4'h1;
	localparam logic [3:0] CMD_READ = 4'h2;
	localparam logic [3:0] CMD_DMC = 4'h3;

	logic  clk;
	logic  rst_n;
	logic  wr_4017;
	byte_t wdata;
	logic  rd_4015;
	logic  dmc_irq;
	logic  quarter_frame;
	logic  half_frame;
	logic  irq;
	logic  frame_irq_flag;

	logic [31:0] gold [0:REC_WORDS*MAX_RECS-1];
	frame_cfg_t  exp_cfg;
	int          quarter_cnt;
	int          half_cnt;
	int          cycle_cnt;
	int          cycle_limit;
	bit          end_reported;

	tb_clock #(.PERIOD(20)) u_clk (.clk(clk));

	frame_counter UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.wr_4017        (wr_4017),
		.wdata          (wdata),
		.rd_4015        (rd_4015),
		.dmc_irq        (dmc_irq),
		.quarter_frame  (quarter_frame),
		.half_frame     (half_frame),
		.irq            (irq),
		.frame_irq_flag (frame_irq_flag)
	);

	bind frame_counter frame_assertions u_assert (
		.clk            (clk),
		.rst_n          (rst_n),
		.step           (step),
		.quarter_frame  (quarter_frame),
		.half_frame     (half_frame),
		.irq            (irq),
		.frame_irq_flag (frame_irq_flag)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		end_reported = 1'b1;
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_cfg(input string name, input frame_cfg_t got, input frame_cfg_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic sample_outputs();
		if (quarter_frame) quarter_cnt++;
		if (half_frame) half_cnt++;
	endtask

	// Command on the first clock, then the rest of the run
	task automatic run_record(input int idx);
		int         base;
		logic [3:0] cmd;
		byte_t      data;
		int         apu_cycles;
		base = idx * REC_WORDS;
		cmd = gold[base][3:0];
		data = gold[base+1][7:0];
		apu_cycles = int'(gold[base+2]);
		quarter_cnt = 0;
		half_cnt = 0;
		@(posedge clk);
		#IN_DELAY;
		case (cmd)
			CMD_WRITE: begin
				wr_4017 = 1'b1;
				wdata = data;
				exp_cfg.mode = data[7];        // 1 = five-step
				exp_cfg.irq_inhibit = data[6];
			end
			CMD_READ: rd_4015 = 1'b1;
			CMD_DMC: dmc_irq = data[0];
			default: ;
		endcase
		@(negedge clk);
		sample_outputs();
		repeat (apu_cycles * `FRAME_APU_DIV - 1) begin
			@(posedge clk);
			#IN_DELAY;
			wr_4017 = 1'b0;
			rd_4015 = 1'b0;
			@(negedge clk);
			sample_outputs();
		end
		check_count($sformatf("quarter_frame count, record %0d", idx), quarter_cnt,
			int'(gold[base+3]));
		check_count($sformatf("half_frame count, record %0d", idx), half_cnt,
			int'(gold[base+4]));
		check_level($sformatf("frame_irq_flag, record %0d", idx), frame_irq_flag, gold[base+5][0]);
		check_level($sformatf("irq, record %0d", idx), irq, gold[base+6][0]);
		check_cfg($sformatf("cfg, record %0d", idx), UUT.cfg, exp_cfg);
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
			$display("SOME TESTS FAILED");
			end_reported = 1'b1;
			$fatal(1, "timeout");
		end
	end

	initial begin
		int n_recs;
		int total_apu;
		int rec;
		rst_n = 1'b0;
		wr_4017 = 1'b0;
		wdata = '0;
		rd_4015 = 1'b0;
		dmc_irq = 1'b0;
		exp_cfg = '0;
		quarter_cnt = 0;
		half_cnt = 0;
		cycle_cnt = 0;
		cycle_limit = 0;
		end_reported = 1'b0;
		$readmemh("frame_golden.txt", gold);
		n_recs = 0;
		total_apu = 0;
		while (n_recs < MAX_RECS && gold[n_recs*REC_WORDS][3:0] != CMD_END) begin
			total_apu += int'(gold[n_recs*REC_WORDS+2]);
			n_recs++;
		end
		if (n_recs == 0) begin
			report_failure("Golden file frame_golden.txt is missing or holds no records");
		end
		cycle_limit = RESET_CYCLES + 2 + (total_apu * `FRAME_APU_DIV * 105) / 100;
		repeat (RESET_CYCLES) @(posedge clk);
		#IN_DELAY;
		rst_n = 1'b1;
		for (rec = 0; rec < n_recs; rec++) begin
			run_record(rec);
		end
		end_reported = 1'b1;
		$display("ALL TESTS PASSED");
		$finish;
	end

	// A failed assertion stops the run from outside this flow
	final begin
		if (!end_reported) begin
			$display("SOME TESTS FAILED");
		end
	end

endmodule

// ==== frame_golden.txt ====
// cmd data apu_cycles quarter half flag irq, all hex
// cmd 1 write 4017, 2 read 4015, 3 set dmc_irq to data bit 0, 4 run only, 0 end
// Counts and levels are taken over the whole record, levels at its last clock
// Four-step sequence after reset sets the flag at its end
4 00 3A98 4 2 1 1
// Inhibit write clears the flag, which stays clear through a sequence
1 40 3A98 4 2 0 0
// Inhibit off, the flag sets again
1 00 3A98 4 2 1 1
// Status read clears it
2 00 1 0 0 0 0
// Five-step, one extra pulse of each at the write, no flag
1 80 490C 5 3 0 0
// Part way into the next five-step sequence
4 00 BB8 0 0 0 0
// Mid-sequence write restarts the count, the old quarter pulse is lost
1 00 E90 0 0 0 0
// First quarter lands 3728 to 3731 APU cycles after the write
4 00 4 1 0 0 0
// irq follows dmc_irq while the flag is clear
3 01 A 0 0 0 1
3 00 A 0 0 0 0
// Rest of the four-step sequence
4 00 2BC0 3 2 1 1
2 00 1 0 0 0 0
0 00 0 0 0 0 0

// ==== frame_counter.f ====
+incdir+.
frame_pkg.sv
frame_timer.sv
frame_ctl.sv
frame_events.sv
frame_counter.sv
tb_clock.sv
frame_assertions.sv
tb_frame_counter.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_frame_counter
FILELIST  := frame_counter.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
